/* common/briey_pkg.sv */
`default_nettype none

package briey_pkg;

  // bus and payload widths
  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 64;
  localparam int HOST_ADDR_W = 64;
  localparam int CORE_ADDR_W = 29;
  localparam int AXI_ID_W    = 12;
  localparam int LINE_W      = 512;
  localparam int STRB_W      = 64;
  localparam int LINE_BYTES  = 64;
  localparam int IDX_W       = 6;
  localparam int LOAD_ADDR_W = 15;
  localparam int USER_W      = 6;
  localparam int ARUSER_W    = 5;

  // core requests from here up take user set 1
  localparam logic [CORE_ADDR_W-1:0] USER_SPLIT_ADDR = 29'h8000;

  // configuration register map
  localparam logic [AXIL_ADDR_W-1:0] REG_ID         = 32'h000;
  localparam logic [AXIL_ADDR_W-1:0] REG_ENABLE     = 32'h010;
  localparam logic [AXIL_ADDR_W-1:0] REG_BASE       = 32'h020;
  localparam logic [AXIL_ADDR_W-1:0] REG_RST_SET    = 32'h030;
  localparam logic [AXIL_ADDR_W-1:0] REG_RST_CLR    = 32'h040;
  localparam logic [AXIL_ADDR_W-1:0] REG_LOAD_EN    = 32'h050;
  localparam logic [AXIL_ADDR_W-1:0] REG_LOAD_IDX   = 32'h060;
  localparam logic [AXIL_ADDR_W-1:0] REG_LOAD_BYTE  = 32'h070;
  localparam logic [AXIL_ADDR_W-1:0] REG_LOAD_FIRE  = 32'h080;
  localparam logic [AXIL_ADDR_W-1:0] REG_LOAD_READY = 32'h090;
  localparam logic [AXIL_ADDR_W-1:0] REG_LOAD_ADDR  = 32'h0a0;
  localparam logic [AXIL_ADDR_W-1:0] REG_USER_WR    = 32'h0e0;
  localparam logic [AXIL_ADDR_W-1:0] REG_USER_RD    = 32'h120;

  // fixed read values
  localparam logic [AXIL_DATA_W-1:0] ID_VALUE       = 64'ha0a1a2a3_deadbeef;
  localparam logic [AXIL_DATA_W-1:0] BAD_READ_VALUE = 64'hdeaddead_deaddead;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // AXI-Lite endpoint FSM encoding
  localparam int AXIL_STATE_W = 2;
  localparam logic [AXIL_STATE_W-1:0] AXIL_IDLE    = 2'd0;
  localparam logic [AXIL_STATE_W-1:0] AXIL_READ    = 2'd1;
  localparam logic [AXIL_STATE_W-1:0] AXIL_WRITE_W = 2'd2;
  localparam logic [AXIL_STATE_W-1:0] AXIL_WRITE_B = 2'd3;

  // program-load line, filled per byte and sent out flat
  typedef union packed {
    logic [LINE_W-1:0]          flat;
    logic [LINE_BYTES-1:0][7:0] bytes;
  } load_line_u;

endpackage

`default_nettype wire

/* cfg/cfg_axil_endpoint.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_axil_endpoint (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [briey_pkg::AXIL_ADDR_W-1:0] awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [briey_pkg::AXIL_DATA_W-1:0] wdata,
  input  logic                              wvalid,
  output logic                              wready,
  output logic                              bvalid,
  input  logic                              bready,
  output logic [1:0]                        bresp,
  input  logic [briey_pkg::AXIL_ADDR_W-1:0] araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [briey_pkg::AXIL_DATA_W-1:0] rdata,
  output logic                              rvalid,
  input  logic                              rready,
  output logic [1:0]                        rresp,
  output logic                              reg_wr,
  output logic [briey_pkg::AXIL_ADDR_W-1:0] reg_waddr,
  output logic [briey_pkg::AXIL_DATA_W-1:0] reg_wdata,
  output logic [briey_pkg::AXIL_ADDR_W-1:0] rd_addr,
  input  logic [briey_pkg::AXIL_DATA_W-1:0] rd_data
);
  import briey_pkg::*;

  logic [AXIL_STATE_W-1:0] state;
  logic [AXIL_STATE_W-1:0] state_next;
  logic [AXIL_ADDR_W-1:0]  waddr_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= AXIL_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      AXIL_IDLE: begin
        // write wins if both arrive together
        if (awvalid) state_next = AXIL_WRITE_W;
        else if (arvalid) state_next = AXIL_READ;
      end
      AXIL_READ:    if (rready) state_next = AXIL_IDLE;
      AXIL_WRITE_W: if (wvalid) state_next = AXIL_WRITE_B;
      AXIL_WRITE_B: if (bready) state_next = AXIL_IDLE;
      default:      state_next = AXIL_IDLE;
    endcase
  end

  // address held for the data phase
  always_ff @(posedge clk) begin
    if (state == AXIL_IDLE && awvalid) waddr_q <= awaddr;
  end

  // last value sampled in idle is the one the read returns
  always_ff @(posedge clk) begin
    if (state == AXIL_IDLE) rdata <= rd_data;
  end

  assign awready = (state == AXIL_IDLE);
  assign arready = (state == AXIL_IDLE) && !awvalid;
  assign wready  = (state == AXIL_WRITE_W);
  assign bvalid  = (state == AXIL_WRITE_B);
  assign rvalid  = (state == AXIL_READ);
  assign bresp   = RESP_OKAY;
  assign rresp   = RESP_OKAY;

  assign reg_wr    = (state == AXIL_WRITE_W) && wvalid;
  assign reg_waddr = waddr_q;
  assign reg_wdata = wdata;
  assign rd_addr   = araddr;

endmodule

`default_nettype wire

/* cfg/cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cfg_regs (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  logic                                   reg_wr,
  input  logic [briey_pkg::AXIL_ADDR_W-1:0]      reg_waddr,
  input  logic [briey_pkg::AXIL_DATA_W-1:0]      reg_wdata,
  input  logic [briey_pkg::AXIL_ADDR_W-1:0]      rd_addr,
  output logic [briey_pkg::AXIL_DATA_W-1:0]      rd_data,
  output logic                                   enable,
  output logic [briey_pkg::HOST_ADDR_W-1:0]      physical_base,
  output logic                                   core_rst,
  output logic [1:0][briey_pkg::USER_W-1:0]      core_awuser,
  output logic [1:0][briey_pkg::USER_W-1:0]      core_aruser,
  input  logic                                   load_en,
  input  logic [briey_pkg::IDX_W-1:0]            load_idx,
  input  logic [briey_pkg::LOAD_ADDR_W-1:0]      load_addr,
  input  logic                                   load_aw_valid,
  input  logic                                   load_w_valid,
  input  logic                                   load_aw_ready,
  input  logic                                   load_w_ready
);
  import briey_pkg::*;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      enable        <= 1'b0;
      physical_base <= '0;
      core_rst      <= 1'b0;
      core_awuser   <= '0;
      core_aruser   <= '0;
    end else if (reg_wr) begin
      case (reg_waddr)
        REG_ENABLE:  enable <= reg_wdata[0];
        REG_BASE:    physical_base <= reg_wdata;
        // core reset is set and cleared at separate offsets
        REG_RST_SET: core_rst <= 1'b1;
        REG_RST_CLR: core_rst <= 1'b0;
        // low to high: wr set 0, wr set 1, rd set 0, rd set 1
        REG_USER_WR: {core_aruser, core_awuser} <= reg_wdata[4*USER_W-1:0];
        default: ;
      endcase
    end
  end

  // loader fields are decoded here for read-back only
  always_comb begin
    case (rd_addr)
      REG_ID:         rd_data = ID_VALUE;
      REG_ENABLE:     rd_data = AXIL_DATA_W'(enable);
      REG_BASE:       rd_data = physical_base;
      REG_LOAD_EN:    rd_data = AXIL_DATA_W'(load_en);
      REG_LOAD_IDX:   rd_data = AXIL_DATA_W'(load_idx);
      REG_LOAD_FIRE:  rd_data = AXIL_DATA_W'({load_aw_valid, load_w_valid});
      REG_LOAD_READY: rd_data = AXIL_DATA_W'({load_aw_ready, load_w_ready});
      REG_LOAD_ADDR:  rd_data = AXIL_DATA_W'(load_addr);
      REG_USER_RD:    rd_data = AXIL_DATA_W'({core_aruser, core_awuser});
      default:        rd_data = BAD_READ_VALUE;
    endcase
  end

endmodule

`default_nettype wire

/* cfg/program_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module program_loader (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              reg_wr,
  input  logic [briey_pkg::AXIL_ADDR_W-1:0] reg_waddr,
  input  logic [briey_pkg::AXIL_DATA_W-1:0] reg_wdata,
  input  logic                              load_aw_ready,
  input  logic                              load_w_ready,
  output logic                              load_en,
  output logic [briey_pkg::IDX_W-1:0]       load_idx,
  output logic [briey_pkg::LOAD_ADDR_W-1:0] load_addr,
  output logic                              load_aw_valid,
  output logic                              load_w_valid,
  output briey_pkg::load_line_u             load_data
);
  import briey_pkg::*;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      load_en       <= 1'b0;
      load_idx      <= '0;
      load_addr     <= '0;
      load_data     <= '0;
      load_aw_valid <= 1'b0;
      load_w_valid  <= 1'b0;
    end else begin
      // each request drops on its own ready
      if (load_aw_ready) load_aw_valid <= 1'b0;
      if (load_w_ready) load_w_valid <= 1'b0;

      if (reg_wr) begin
        case (reg_waddr)
          REG_LOAD_EN:   load_en <= reg_wdata[0];
          REG_LOAD_IDX:  load_idx <= reg_wdata[IDX_W-1:0];
          // one byte per write, placed at the current index
          REG_LOAD_BYTE: load_data.bytes[load_idx] <= reg_wdata[7:0];
          REG_LOAD_FIRE: begin
            // a new fire overrides a same-cycle ready
            load_aw_valid <= 1'b1;
            load_w_valid  <= 1'b1;
          end
          REG_LOAD_ADDR: load_addr <= reg_wdata[LOAD_ADDR_W-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* source/cxl_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module cxl_bridge (
  input  logic                              enable,
  input  logic [briey_pkg::HOST_ADDR_W-1:0] physical_base,
  input  logic [1:0][briey_pkg::USER_W-1:0] core_awuser,
  input  logic [1:0][briey_pkg::USER_W-1:0] core_aruser,
  // core side
  input  logic [briey_pkg::CORE_ADDR_W-1:0] core_awaddr,
  input  logic [briey_pkg::AXI_ID_W-1:0]    core_awid,
  input  logic                              core_awvalid,
  output logic                              core_awready,
  input  logic [briey_pkg::LINE_W-1:0]      core_wdata,
  input  logic [briey_pkg::STRB_W-1:0]      core_wstrb,
  input  logic                              core_wvalid,
  output logic                              core_wready,
  output logic [briey_pkg::AXI_ID_W-1:0]    core_bid,
  output logic                              core_bvalid,
  input  logic                              core_bready,
  input  logic [briey_pkg::CORE_ADDR_W-1:0] core_araddr,
  input  logic [briey_pkg::AXI_ID_W-1:0]    core_arid,
  input  logic                              core_arvalid,
  output logic                              core_arready,
  output logic                              core_rvalid,
  input  logic                              core_rready,
  // host side
  output logic [briey_pkg::HOST_ADDR_W-1:0] awaddr,
  output logic [briey_pkg::AXI_ID_W-1:0]    awid,
  output logic [briey_pkg::USER_W-1:0]      awuser,
  output logic                              awvalid,
  input  logic                              awready,
  output logic [briey_pkg::LINE_W-1:0]      wdata,
  output logic [briey_pkg::STRB_W-1:0]      wstrb,
  output logic                              wvalid,
  input  logic                              wready,
  input  logic [briey_pkg::AXI_ID_W-1:0]    bid,
  input  logic                              bvalid,
  output logic                              bready,
  output logic [briey_pkg::HOST_ADDR_W-1:0] araddr,
  output logic [briey_pkg::AXI_ID_W-1:0]    arid,
  output logic [briey_pkg::ARUSER_W-1:0]    aruser,
  output logic                              arvalid,
  input  logic                              arready,
  input  logic                              rvalid,
  output logic                              rready
);
  import briey_pkg::*;

  logic [USER_W-1:0] aruser_set;

  // nothing crosses while the bridge is disabled
  assign awvalid      = core_awvalid && enable;
  assign wvalid       = core_wvalid && enable;
  assign arvalid      = core_arvalid && enable;
  assign core_bvalid  = bvalid && enable;
  assign core_rvalid  = rvalid && enable;
  assign core_awready = awready && enable;
  assign core_wready  = wready && enable;
  assign core_arready = arready && enable;

  // drain host responses when disabled
  assign bready = core_bready || !enable;
  assign rready = core_rready || !enable;

  // core byte address offset into host memory
  assign awaddr = physical_base + HOST_ADDR_W'(core_awaddr);
  assign araddr = physical_base + HOST_ADDR_W'(core_araddr);

  assign awuser     = (core_awaddr >= USER_SPLIT_ADDR) ? core_awuser[1] : core_awuser[0];
  assign aruser_set = (core_araddr >= USER_SPLIT_ADDR) ? core_aruser[1] : core_aruser[0];
  assign aruser     = aruser_set[ARUSER_W-1:0];

  assign awid     = core_awid;
  assign arid     = core_arid;
  assign core_bid = bid;
  assign wdata    = core_wdata;
  assign wstrb    = core_wstrb;

endmodule

`default_nettype wire

/* source/briey_host_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module briey_host_shell (
  input  logic                              clk,
  input  logic                              rstn,
  // host AXI-Lite configuration port
  input  logic [briey_pkg::AXIL_ADDR_W-1:0] axil_awaddr,
  input  logic                              axil_awvalid,
  output logic                              axil_awready,
  input  logic [briey_pkg::AXIL_DATA_W-1:0] axil_wdata,
  input  logic                              axil_wvalid,
  output logic                              axil_wready,
  output logic                              axil_bvalid,
  input  logic                              axil_bready,
  output logic [1:0]                        axil_bresp,
  input  logic [briey_pkg::AXIL_ADDR_W-1:0] axil_araddr,
  input  logic                              axil_arvalid,
  output logic                              axil_arready,
  output logic [briey_pkg::AXIL_DATA_W-1:0] axil_rdata,
  output logic                              axil_rvalid,
  input  logic                              axil_rready,
  output logic [1:0]                        axil_rresp,
  // core control and instruction RAM load
  output logic                              core_rst,
  output logic                              load_en,
  output logic [briey_pkg::LOAD_ADDR_W-1:0] load_addr,
  output logic [briey_pkg::LINE_W-1:0]      load_data,
  output logic                              load_aw_valid,
  input  logic                              load_aw_ready,
  output logic                              load_w_valid,
  input  logic                              load_w_ready,
  // core memory requests
  input  logic [briey_pkg::CORE_ADDR_W-1:0] core_awaddr,
  input  logic [briey_pkg::AXI_ID_W-1:0]    core_awid,
  input  logic                              core_awvalid,
  output logic                              core_awready,
  input  logic [briey_pkg::LINE_W-1:0]      core_wdata,
  input  logic [briey_pkg::STRB_W-1:0]      core_wstrb,
  input  logic                              core_wvalid,
  output logic                              core_wready,
  output logic [briey_pkg::AXI_ID_W-1:0]    core_bid,
  output logic [1:0]                        core_bresp,
  output logic                              core_bvalid,
  input  logic                              core_bready,
  input  logic [briey_pkg::CORE_ADDR_W-1:0] core_araddr,
  input  logic [briey_pkg::AXI_ID_W-1:0]    core_arid,
  input  logic                              core_arvalid,
  output logic                              core_arready,
  output logic [briey_pkg::AXI_ID_W-1:0]    core_rid,
  output logic [briey_pkg::LINE_W-1:0]      core_rdata,
  output logic [1:0]                        core_rresp,
  output logic                              core_rlast,
  output logic                              core_rvalid,
  input  logic                              core_rready,
  // host AXI memory port
  output logic [briey_pkg::HOST_ADDR_W-1:0] awaddr,
  output logic [briey_pkg::AXI_ID_W-1:0]    awid,
  output logic [briey_pkg::USER_W-1:0]      awuser,
  output logic                              awvalid,
  input  logic                              awready,
  output logic [briey_pkg::LINE_W-1:0]      wdata,
  output logic [briey_pkg::STRB_W-1:0]      wstrb,
  output logic                              wvalid,
  input  logic                              wready,
  input  logic [briey_pkg::AXI_ID_W-1:0]    bid,
  input  logic [1:0]                        bresp,
  input  logic                              bvalid,
  output logic                              bready,
  output logic [briey_pkg::HOST_ADDR_W-1:0] araddr,
  output logic [briey_pkg::AXI_ID_W-1:0]    arid,
  output logic [briey_pkg::ARUSER_W-1:0]    aruser,
  output logic                              arvalid,
  input  logic                              arready,
  input  logic [briey_pkg::AXI_ID_W-1:0]    rid,
  input  logic [briey_pkg::LINE_W-1:0]      rdata,
  input  logic [1:0]                        rresp,
  input  logic                              rlast,
  input  logic                              rvalid,
  output logic                              rready
);
  import briey_pkg::*;

  logic                    reg_wr;
  logic [AXIL_ADDR_W-1:0]  reg_waddr;
  logic [AXIL_DATA_W-1:0]  reg_wdata;
  logic [AXIL_ADDR_W-1:0]  rd_addr;
  logic [AXIL_DATA_W-1:0]  rd_data;
  logic                    enable;
  logic [HOST_ADDR_W-1:0]  physical_base;
  logic [1:0][USER_W-1:0]  core_awuser;
  logic [1:0][USER_W-1:0]  core_aruser;
  logic [IDX_W-1:0]        load_idx;
  load_line_u              load_line;

  cfg_axil_endpoint u_endpoint (
    .clk       (clk),
    .rstn      (rstn),
    .awaddr    (axil_awaddr),
    .awvalid   (axil_awvalid),
    .awready   (axil_awready),
    .wdata     (axil_wdata),
    .wvalid    (axil_wvalid),
    .wready    (axil_wready),
    .bvalid    (axil_bvalid),
    .bready    (axil_bready),
    .bresp     (axil_bresp),
    .araddr    (axil_araddr),
    .arvalid   (axil_arvalid),
    .arready   (axil_arready),
    .rdata     (axil_rdata),
    .rvalid    (axil_rvalid),
    .rready    (axil_rready),
    .rresp     (axil_rresp),
    .reg_wr    (reg_wr),
    .reg_waddr (reg_waddr),
    .reg_wdata (reg_wdata),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  cfg_regs u_regs (.*);

  program_loader u_loader (
    .load_data (load_line),
    .*
  );

  cxl_bridge u_bridge (.*);

  // line leaves the shell in its flat view
  assign load_data = load_line.flat;

  // response payloads go straight to the core
  assign core_bresp = bresp;
  assign core_rid   = rid;
  assign core_rdata = rdata;
  assign core_rresp = rresp;
  assign core_rlast = rlast;

endmodule

`default_nettype wire

/* verification/tb_briey_host_shell.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_briey_host_shell;
  import briey_pkg::*;

  localparam int OP_WR = 0, OP_RD = 1, OP_CORE_WR = 2, OP_CORE_RD = 3;
  localparam int WAIT_MAX = 50;

  typedef struct packed {
    int                     op;
    logic [AXIL_ADDR_W-1:0] addr;
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_DATA_W-1:0] exp;
  } entry_t;

  logic clk = 1'b0, rstn = 1'b0;
  logic [AXIL_ADDR_W-1:0] axil_awaddr, axil_araddr;
  logic [AXIL_DATA_W-1:0] axil_wdata, axil_rdata;
  logic axil_awvalid, axil_awready, axil_wvalid, axil_wready, axil_bvalid, axil_bready;
  logic axil_arvalid, axil_arready, axil_rvalid, axil_rready;
  logic [1:0] axil_bresp, axil_rresp, core_bresp, core_rresp, bresp, rresp;
  logic core_rst, load_en, load_aw_valid, load_aw_ready, load_w_valid, load_w_ready;
  logic [LOAD_ADDR_W-1:0] load_addr;
  logic [LINE_W-1:0] load_data, core_wdata, core_rdata, wdata, rdata;
  logic [CORE_ADDR_W-1:0] core_awaddr, core_araddr;
  logic [AXI_ID_W-1:0] core_awid, core_bid, core_arid, core_rid, awid, bid, arid, rid;
  logic [STRB_W-1:0] core_wstrb, wstrb;
  logic core_awvalid, core_awready, core_wvalid, core_wready, core_bvalid, core_bready;
  logic core_arvalid, core_arready, core_rvalid, core_rready, core_rlast, rlast;
  logic [HOST_ADDR_W-1:0] awaddr, araddr;
  logic [USER_W-1:0] awuser;
  logic [ARUSER_W-1:0] aruser;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  logic [31:0] rng = 32'hb2a8_815a;
  logic [AXIL_DATA_W-1:0] user_word, base_word, rd_val;
  load_line_u line_model;
  entry_t stim_q[$];
  entry_t e;
  int n, d_aw, d_w;

  briey_host_shell dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [LINE_W-1:0] random_line();
    logic [LINE_W-1:0] v;
    for (int i = 0; i < LINE_W / 32; i++) v[i*32 +: 32] = xorshift();
    return v;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [AXIL_DATA_W-1:0] got,
                            input logic [AXIL_DATA_W-1:0] exp);
    if (got !== exp) fail_now($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_line(input string name, input logic [LINE_W-1:0] got,
                            input logic [LINE_W-1:0] exp);
    if (got !== exp) fail_now($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [HOST_ADDR_W-1:0] got,
                            input logic [HOST_ADDR_W-1:0] exp);
    if (got !== exp) fail_now($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_user(input string name, input logic [USER_W-1:0] got,
                            input logic [USER_W-1:0] exp);
    if (got !== exp) fail_now($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task automatic axil_write(input logic [AXIL_ADDR_W-1:0] a, input logic [AXIL_DATA_W-1:0] d);
    int k;
    axil_awaddr = a;
    axil_awvalid = 1'b1;
    axil_wdata = d;
    axil_wvalid = 1'b1;
    for (k = 0; !axil_awready; k++) begin
      if (k > WAIT_MAX) fail_now("timeout waiting for awready");
      @(negedge clk);
    end
    @(negedge clk);
    axil_awvalid = 1'b0;
    for (k = 0; !axil_wready; k++) begin
      if (k > WAIT_MAX) fail_now("timeout waiting for wready");
      @(negedge clk);
    end
    @(negedge clk);
    axil_wvalid = 1'b0;
    axil_bready = 1'b1;
    for (k = 0; !axil_bvalid; k++) begin
      if (k > WAIT_MAX) fail_now("timeout waiting for bvalid");
      @(negedge clk);
    end
    check_word("axil_bresp", axil_bresp, RESP_OKAY);
    @(negedge clk);
    axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [AXIL_ADDR_W-1:0] a, output logic [AXIL_DATA_W-1:0] d);
    int k;
    axil_araddr = a;
    axil_arvalid = 1'b1;
    for (k = 0; !axil_arready; k++) begin
      if (k > WAIT_MAX) fail_now("timeout waiting for arready");
      @(negedge clk);
    end
    @(negedge clk);
    axil_arvalid = 1'b0;
    axil_rready = 1'b1;
    for (k = 0; !axil_rvalid; k++) begin
      if (k > WAIT_MAX) fail_now("timeout waiting for rvalid");
      @(negedge clk);
    end
    d = axil_rdata;
    check_word("axil_rresp", axil_rresp, RESP_OKAY);
    @(negedge clk);
    axil_rready = 1'b0;
  endtask

  // drive every valid and ready at once and look at what crosses
  task automatic check_gating(input logic en);
    {core_awvalid, core_wvalid, core_arvalid, core_bready, core_rready} = '1;
    {awready, wready, arready, bvalid, rvalid} = '1;
    #1;
    check_word("awvalid", awvalid, en);
    check_word("wvalid", wvalid, en);
    check_word("arvalid", arvalid, en);
    check_word("core_awready", core_awready, en);
    check_word("core_wready", core_wready, en);
    check_word("core_arready", core_arready, en);
    check_word("core_bvalid", core_bvalid, en);
    check_word("core_rvalid", core_rvalid, en);
    check_word("bready", bready, 1);
    check_word("rready", rready, 1);
    {core_bready, core_rready} = '0;
    #1;
    check_word("bready", bready, !en);
    check_word("rready", rready, !en);
    @(negedge clk);
    {core_awvalid, core_wvalid, core_arvalid} = '0;
    {awready, wready, arready, bvalid, rvalid} = '0;
  endtask

  // payloads and IDs cross the shell unchanged
  task automatic check_payloads();
    core_awid = AXI_ID_W'(xorshift());
    core_arid = AXI_ID_W'(xorshift());
    core_wdata = random_line();
    core_wstrb = {xorshift(), xorshift()};
    bid = AXI_ID_W'(xorshift());
    rid = AXI_ID_W'(xorshift());
    rdata = random_line();
    {rlast, rresp, bresp} = 5'(xorshift());
    #1;
    check_word("awid", awid, core_awid);
    check_word("arid", arid, core_arid);
    check_line("wdata", wdata, core_wdata);
    check_word("wstrb", wstrb, core_wstrb);
    check_word("core_bid", core_bid, bid);
    check_word("core_bresp", core_bresp, bresp);
    check_word("core_rid", core_rid, rid);
    check_line("core_rdata", core_rdata, rdata);
    check_word("core_rresp", core_rresp, rresp);
    check_word("core_rlast", core_rlast, rlast);
    @(negedge clk);
  endtask

  // expected user field from the address half and the request direction
  function automatic logic [USER_W-1:0] user_of(input logic [CORE_ADDR_W-1:0] a, input int rd);
    int sel;
    sel = 2 * rd + ((a >= 29'h8000) ? 1 : 0);
    return user_word[sel*USER_W +: USER_W];
  endfunction

  task automatic add_entry(input int op, input logic [31:0] a, input logic [63:0] d,
                           input logic [63:0] x);
    entry_t t;
    t.op = op;
    t.addr = a;
    t.data = d;
    t.exp = x;
    stim_q.push_back(t);
  endtask

  initial begin
    axil_awaddr = '0;
    axil_awvalid = 1'b0;
    axil_wdata = '0;
    axil_wvalid = 1'b0;
    axil_bready = 1'b0;
    axil_araddr = '0;
    axil_arvalid = 1'b0;
    axil_rready = 1'b0;
    load_aw_ready = 1'b0;
    load_w_ready = 1'b0;
    core_awaddr = '0;
    core_awid = '0;
    core_awvalid = 1'b0;
    core_wdata = '0;
    core_wstrb = '0;
    core_wvalid = 1'b0;
    core_bready = 1'b0;
    core_araddr = '0;
    core_arid = '0;
    core_arvalid = 1'b0;
    core_rready = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    bid = '0;
    bresp = '0;
    bvalid = 1'b0;
    arready = 1'b0;
    rid = '0;
    rdata = '0;
    rresp = '0;
    rlast = 1'b0;
    rvalid = 1'b0;
    repeat (8) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_word("enable", dut.enable, 0);
    check_word("core_rst", core_rst, 0);
    check_word("load_en", load_en, 0);
    check_word("load_aw_valid", load_aw_valid, 0);
    check_word("load_w_valid", load_w_valid, 0);
    check_word("load_addr", load_addr, 0);
    check_line("load_data", load_data, '0);

    base_word = {xorshift(), xorshift()};
    user_word = 64'(xorshift() & 32'h00ff_ffff);
    n = xorshift();
    add_entry(OP_RD, REG_ID, 0, ID_VALUE);
    add_entry(OP_RD, 32'h200, 0, BAD_READ_VALUE);
    add_entry(OP_WR, REG_ENABLE, 1, 0);
    add_entry(OP_RD, REG_ENABLE, 0, 1);
    add_entry(OP_WR, REG_BASE, base_word, 0);
    add_entry(OP_RD, REG_BASE, 0, base_word);
    add_entry(OP_WR, REG_LOAD_IDX, n, 0);
    add_entry(OP_RD, REG_LOAD_IDX, 0, n & 32'h3f);
    add_entry(OP_WR, REG_LOAD_ADDR, n, 0);
    add_entry(OP_RD, REG_LOAD_ADDR, 0, n & 32'h7fff);
    add_entry(OP_WR, REG_USER_WR, user_word, 0);
    add_entry(OP_RD, REG_USER_RD, 0, user_word);
    for (int i = 0; i < 4; i++) begin
      n = (i % 2) ? 32'h8000 + (xorshift() & 32'h0fff_ffff) : xorshift() & 32'h7fff;
      add_entry(OP_CORE_WR + i / 2, n, 0, base_word + 64'(n));
    end
    add_entry(OP_CORE_RD, 32'h8000, 0, base_word + 64'h8000);
    add_entry(OP_CORE_WR, 32'h7fff, 0, base_word + 64'h7fff);

    foreach (stim_q[i]) begin
      e = stim_q[i];
      case (e.op)
        OP_WR: axil_write(e.addr, e.data);
        OP_RD: begin
          axil_read(e.addr, rd_val);
          check_word($sformatf("rdata@%h", e.addr), rd_val, e.exp);
        end
        OP_CORE_WR: begin
          core_awaddr = e.addr;
          #1;
          check_addr("awaddr", awaddr, e.exp);
          check_user("awuser", awuser, user_of(e.addr, 0));
          @(negedge clk);
        end
        default: begin
          core_araddr = e.addr;
          #1;
          check_addr("araddr", araddr, e.exp);
          check_user("aruser", USER_W'(aruser), user_of(e.addr, 1) & 6'h1f);
          @(negedge clk);
        end
      endcase
    end
    check_user("core_awuser[0]", dut.core_awuser[0], user_word[5:0]);
    check_user("core_awuser[1]", dut.core_awuser[1], user_word[11:6]);
    check_user("core_aruser[0]", dut.core_aruser[0], user_word[17:12]);
    check_user("core_aruser[1]", dut.core_aruser[1], user_word[23:18]);

    check_payloads();

    check_gating(1'b1);
    axil_write(REG_ENABLE, 0);
    check_gating(1'b0);
    axil_write(REG_ENABLE, 1);
    check_gating(1'b1);

    // program load of a few random bytes
    line_model.flat = '0;
    axil_write(REG_LOAD_EN, 1);
    check_word("load_en", load_en, 1);
    n = xorshift();
    axil_write(REG_LOAD_ADDR, n);
    check_word("load_addr", load_addr, n & 32'h7fff);
    for (int i = 0; i < 6; i++) begin
      n = xorshift();
      axil_write(REG_LOAD_IDX, n);
      axil_write(REG_LOAD_BYTE, n >> 8);
      line_model.bytes[n[5:0]] = n[15:8];
    end
    axil_write(REG_LOAD_FIRE, 1);
    check_line("load_data", load_data, line_model.flat);
    axil_read(REG_LOAD_FIRE, rd_val);
    check_word("load fire level", rd_val, 3);
    d_aw = xorshift() % 6;
    d_w = d_aw + 1 + xorshift() % 5;
    for (int c = 0; c <= d_w + 1; c++) begin
      check_word("load_aw_valid", load_aw_valid, c <= d_aw);
      check_word("load_w_valid", load_w_valid, c <= d_w);
      load_aw_ready = (c == d_aw);
      load_w_ready = (c == d_w);
      @(negedge clk);
    end
    load_aw_ready = 1'b1;
    axil_read(REG_LOAD_READY, rd_val);
    check_word("load ready level", rd_val, 2);
    load_aw_ready = 1'b0;
    axil_read(REG_LOAD_FIRE, rd_val);
    check_word("load fire level", rd_val, 0);

    axil_write(REG_RST_SET, 0);
    check_word("core_rst", core_rst, 1);
    axil_write(REG_RST_CLR, 0);
    check_word("core_rst", core_rst, 0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/briey_pkg.sv
cfg/cfg_axil_endpoint.sv
cfg/cfg_regs.sv
cfg/program_loader.sv
source/cxl_bridge.sv
source/briey_host_shell.sv
verification/tb_briey_host_shell.sv
